// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/pc_gen.sv
      - hdl/icache.sv
      - hdl/icache_ctrl.sv
      - hdl/branch_predictor.sv
      - hdl/fetch_stage.sv
  - target: test
    files:
      - bench/fetch_tb.sv

// ==== bench/fetch_tb.sv ====
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_WORDS   = 64;
    localparam int LINE_BYTES  = fetch_pkg::LINE_BITS / 8;
    localparam int MAX_RECORDS = 64;

    // record kinds of the test data file
    localparam logic [31:0] REC_END   = 32'd0;
    localparam logic [31:0] REC_MEM   = 32'd1;
    localparam logic [31:0] REC_EXP   = 32'd2;
    localparam logic [31:0] REC_STALL = 32'd3;
    localparam logic [31:0] REC_REDIR = 32'd4;
    localparam logic [31:0] REC_UPD   = 32'd5;

    logic                            clk_i;
    logic                            rst_n_i;
    logic                            stall_i;
    logic                            redirect_valid_i;
    logic [fetch_pkg::XLEN-1:0]      redirect_pc_i;
    logic                            upd_valid_i;
    logic [fetch_pkg::XLEN-1:0]      upd_pc_i;
    logic                            upd_taken_i;
    logic [fetch_pkg::XLEN-1:0]      upd_target_i;
    logic                            instr_valid_o;
    logic [fetch_pkg::XLEN-1:0]      pc_o;
    logic [fetch_pkg::XLEN-1:0]      instr_o;
    logic                            pred_taken_o;
    logic                            mem_req_o;
    logic [fetch_pkg::XLEN-1:0]      mem_addr_o;
    logic                            mem_valid_i;
    logic [fetch_pkg::LINE_BITS-1:0] mem_line_i;

    logic [31:0]                testdata    [4*MAX_RECORDS];
    logic [31:0]                mem_words   [MEM_WORDS];
    logic                       line_seen   [MEM_WORDS*4/LINE_BYTES];
    logic [fetch_pkg::XLEN-1:0] got_pc_q    [$];
    logic [fetch_pkg::XLEN-1:0] got_instr_q [$];
    logic                       got_pred_q  [$];

    int                         cycle_count;
    int                         cycle_limit;
    logic                       mem_pending;
    int                         mem_delay;
    logic [fetch_pkg::XLEN-1:0] mem_req_addr;
    logic                       redirect_seen;
    logic [fetch_pkg::XLEN-1:0] redirect_target;

    fetch_stage fetch_stage_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_taken_i      (upd_taken_i),
        .upd_target_i     (upd_target_i),
        .instr_valid_o    (instr_valid_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o),
        .pred_taken_o     (pred_taken_o),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .mem_valid_i      (mem_valid_i),
        .mem_line_i       (mem_line_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ************************************************************
    // checks
    // ************************************************************
    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_instr(input string name, input logic [fetch_pkg::XLEN-1:0] got,
                               input logic [fetch_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [fetch_pkg::XLEN-1:0] got,
                              input logic [fetch_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // ************************************************************
    // memory model and delivery monitor
    // ************************************************************
    function automatic logic [fetch_pkg::LINE_BITS-1:0] read_line(
        input logic [fetch_pkg::XLEN-1:0] addr
    );
        logic [fetch_pkg::LINE_BITS-1:0] line;
        int                              base;
        base = int'(addr >> 2) % MEM_WORDS;
        for (int k = 0; k < fetch_pkg::WORDS_PER_LINE; k++) begin
            line[k*fetch_pkg::XLEN +: fetch_pkg::XLEN] = mem_words[base + k];
        end
        return line;
    endfunction

    always @(posedge clk_i) begin
        mem_valid_i <= 1'b0;
        if (mem_pending) begin
            if (mem_delay == 0) begin
                mem_valid_i <= 1'b1;
                mem_line_i  <= read_line(mem_req_addr);
                mem_pending = 1'b0;
            end else begin
                mem_delay = mem_delay - 1;
            end
        end
        if (rst_n_i && mem_req_o) begin
            if (mem_pending) begin
                report_failure("a memory request was issued while another one was outstanding");
            end
            check_addr("mem_addr_o line offset",
                       mem_addr_o & fetch_pkg::XLEN'(LINE_BYTES - 1), '0);
            if (mem_addr_o >= MEM_WORDS * 4) begin
                report_failure("a memory request fell outside the memory image");
            end
            if (line_seen[mem_addr_o / LINE_BYTES]) begin
                report_failure("a memory request named a line that was already fetched");
            end
            line_seen[mem_addr_o / LINE_BYTES] = 1'b1;
            mem_req_addr = mem_addr_o;
            mem_delay    = $urandom_range(8, 1) - 1;
            mem_pending  = 1'b1;
        end
    end

    // deliveries seen while a redirect is applied belong to the old path
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                report_failure("timeout: the expected instruction stream did not complete");
            end
            if (instr_valid_o && !redirect_valid_i) begin
                got_pc_q.push_back(pc_o);
                got_instr_q.push_back(instr_o);
                got_pred_q.push_back(pred_taken_o);
            end
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic expect_instr(input logic [fetch_pkg::XLEN-1:0] pc_exp,
                                input logic [fetch_pkg::XLEN-1:0] instr_exp,
                                input logic pred_exp);
        logic [fetch_pkg::XLEN-1:0] pc_got;
        logic [fetch_pkg::XLEN-1:0] instr_got;
        logic                       pred_got;
        while (got_pc_q.size() == 0) begin
            @(negedge clk_i);
        end
        pc_got    = got_pc_q.pop_front();
        instr_got = got_instr_q.pop_front();
        pred_got  = got_pred_q.pop_front();
        if (redirect_seen) begin
            check_instr("pc_o after redirect", pc_got, redirect_target);
            redirect_seen = 1'b0;
        end
        check_instr("pc_o", pc_got, pc_exp);
        check_instr("instr_o", instr_got, instr_exp);
        check_flag("pred_taken_o", pred_got, pred_exp);
    endtask

    task automatic run_stall(input int cycles);
        logic [fetch_pkg::XLEN-1:0] pc_hold;
        logic [fetch_pkg::XLEN-1:0] instr_hold;
        @(posedge clk_i);
        stall_i <= 1'b1;
        @(posedge clk_i);
        pc_hold    = pc_o;
        instr_hold = instr_o;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            if (instr_valid_o) begin
                report_failure("instr_valid_o went high while stall_i was held");
            end
            check_instr("pc_o during stall", pc_o, pc_hold);
            check_instr("instr_o during stall", instr_o, instr_hold);
            if (i == cycles - 1) begin
                stall_i <= 1'b0;
            end
        end
    endtask

    task automatic apply_redirect(input logic [fetch_pkg::XLEN-1:0] target);
        @(posedge clk_i);
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= target;
        @(posedge clk_i);
        redirect_valid_i <= 1'b0;
        got_pc_q.delete();
        got_instr_q.delete();
        got_pred_q.delete();
        redirect_seen   = 1'b1;
        redirect_target = target;
    endtask

    task automatic apply_update(input logic [fetch_pkg::XLEN-1:0] pc, input logic taken,
                                input logic [fetch_pkg::XLEN-1:0] target);
        @(posedge clk_i);
        upd_valid_i  <= 1'b1;
        upd_pc_i     <= pc;
        upd_taken_i  <= taken;
        upd_target_i <= target;
        @(posedge clk_i);
        upd_valid_i <= 1'b0;
    endtask

    initial begin
        int          rec;
        int          exp_count;
        int          stall_total;
        logic [31:0] kind;
        logic [31:0] addr;
        stall_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = '0;
        upd_valid_i      = 1'b0;
        upd_pc_i         = '0;
        upd_taken_i      = 1'b0;
        upd_target_i     = '0;
        mem_valid_i      = 1'b0;
        mem_line_i       = '0;
        rst_n_i          = 1'b0;
        void'($urandom(32'h91d3));
        cycle_count      = 0;
        cycle_limit      = 0;
        mem_pending      = 1'b0;
        mem_delay        = 0;
        redirect_seen    = 1'b0;
        exp_count        = 0;
        stall_total      = 0;

        for (int i = 0; i < 4 * MAX_RECORDS; i++) begin
            testdata[i] = REC_END;
        end
        $readmemh("bench/fetch_testdata.txt", testdata);

        // background image is a rotated address, so no word decodes as a branch
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr         = i * 4;
            mem_words[i] = 32'h1300_0000 ^ {addr[30:0], addr[31]};
        end
        for (int i = 0; i < MEM_WORDS * 4 / LINE_BYTES; i++) begin
            line_seen[i] = 1'b0;
        end

        for (rec = 0; rec < MAX_RECORDS && testdata[4*rec] != REC_END; rec++) begin
            kind = testdata[4*rec];
            if (kind == REC_MEM) begin
                mem_words[int'(testdata[4*rec+1] >> 2) % MEM_WORDS] = testdata[4*rec+2];
            end else if (kind == REC_EXP) begin
                exp_count = exp_count + 1;
            end else if (kind == REC_STALL) begin
                stall_total = stall_total + testdata[4*rec+1];
            end
        end
        cycle_limit = 64 * exp_count + stall_total;

        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;

        for (rec = 0; rec < MAX_RECORDS && testdata[4*rec] != REC_END; rec++) begin
            kind = testdata[4*rec];
            case (kind)
                REC_MEM:   ;
                REC_EXP:   expect_instr(testdata[4*rec+1], testdata[4*rec+2],
                                        testdata[4*rec+3][0]);
                REC_STALL: run_stall(testdata[4*rec+1]);
                REC_REDIR: apply_redirect(testdata[4*rec+1]);
                REC_UPD:   apply_update(testdata[4*rec+1], testdata[4*rec+2][0],
                                        testdata[4*rec+3]);
                default:   report_failure("the test data file holds an unknown record kind");
            endcase
        end

        $display("Test OK");
        $finish;
    end

endmodule

// ==== bench/fetch_testdata.txt ====
// kind, then pc or address, then instruction or data or taken, then pred flag or target
// kinds: 1 memory word, 2 expected delivery, 3 stall cycles, 4 redirect pc, 5 predictor update
1 00000040 04000063 00000000
5 00000040 00000001 00000080
5 00000040 00000001 00000080
5 0000004c 00000001 000000c0
5 0000004c 00000001 000000c0
// cold start across three lines with a stall in between
2 00000000 13000000 00000000
2 00000004 13000008 00000000
2 00000008 13000010 00000000
2 0000000c 13000018 00000000
2 00000010 13000020 00000000
2 00000014 13000028 00000000
3 00000006 00000000 00000000
2 00000018 13000030 00000000
2 0000001c 13000038 00000000
2 00000020 13000040 00000000
2 00000024 13000048 00000000
2 00000028 13000050 00000000
2 0000002c 13000058 00000000
// loop back over cached lines into the branch that was trained taken
4 00000028 00000000 00000000
2 00000028 13000050 00000000
2 0000002c 13000058 00000000
2 00000030 13000060 00000000
2 00000034 13000068 00000000
2 00000038 13000070 00000000
2 0000003c 13000078 00000000
2 00000040 04000063 00000001
2 00000080 13000100 00000000
2 00000084 13000108 00000000
// train the branch back to not taken, then pass it and the trained non-branch word
5 00000040 00000000 00000080
5 00000040 00000000 00000080
4 0000003c 00000000 00000000
2 0000003c 13000078 00000000
2 00000040 04000063 00000000
2 00000044 13000088 00000000
2 00000048 13000090 00000000
2 0000004c 13000098 00000000
2 00000050 130000a0 00000000

// ==== hdl/branch_predictor.sv ====
module branch_predictor (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0] fetch_pc_i,
    input  logic [fetch_pkg::XLEN-1:0] word_i,
    input  logic                       deliver_i,
    input  logic                       upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
    input  logic                       upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_target_i,
    output logic                       pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0] pred_target_o,
    output logic                       pred_taken_reg_o
);

    logic [1:0]                        cnt_q        [fetch_pkg::BP_ENTRIES];
    logic [fetch_pkg::BP_ENTRIES-1:0]  btb_valid_q;
    logic [fetch_pkg::BP_TAG_BITS-1:0] btb_tag_q    [fetch_pkg::BP_ENTRIES];
    logic [fetch_pkg::XLEN-1:0]        btb_target_q [fetch_pkg::BP_ENTRIES];
    logic                              pred_taken_q;

    fetch_pkg::opcode_e                  op;
    logic [fetch_pkg::BP_INDEX_BITS-1:0] rd_idx;
    logic [fetch_pkg::BP_INDEX_BITS-1:0] upd_idx;
    logic                                btb_hit;

    always_comb begin
        case (word_i[6:0])
            fetch_pkg::OPC_BRANCH: op = fetch_pkg::BRANCH;
            fetch_pkg::OPC_JAL:    op = fetch_pkg::JAL;
            fetch_pkg::OPC_JALR:   op = fetch_pkg::JALR;
            default:               op = fetch_pkg::OTHER;
        endcase
    end

    assign rd_idx  = fetch_pc_i[2 +: fetch_pkg::BP_INDEX_BITS];
    assign upd_idx = upd_pc_i[2 +: fetch_pkg::BP_INDEX_BITS];
    assign btb_hit = btb_valid_q[rd_idx] &&
                     (btb_tag_q[rd_idx] == fetch_pc_i[fetch_pkg::XLEN-1 -: fetch_pkg::BP_TAG_BITS]);

    // jalr targets live in a register, so only direct control flow is steered
    assign pred_taken_o  = btb_hit && cnt_q[rd_idx][1] &&
                           ((op == fetch_pkg::BRANCH) || (op == fetch_pkg::JAL));
    assign pred_target_o = btb_target_q[rd_idx];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++) begin
                cnt_q[i] <= 2'd1;
            end
            btb_valid_q  <= '0;
            pred_taken_q <= 1'b0;
        end else begin
            pred_taken_q <= deliver_i && pred_taken_o;
            if (upd_valid_i) begin
                btb_valid_q[upd_idx] <= 1'b1;
                if (upd_taken_i && (cnt_q[upd_idx] != 2'd3)) begin
                    cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'd1;
                end else if (!upd_taken_i && (cnt_q[upd_idx] != 2'd0)) begin
                    cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd_valid_i) begin
            btb_tag_q[upd_idx]    <= upd_pc_i[fetch_pkg::XLEN-1 -: fetch_pkg::BP_TAG_BITS];
            btb_target_q[upd_idx] <= upd_target_i;
        end
    end

    assign pred_taken_reg_o = pred_taken_q;

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // ************************************************************
    // datapath and cache geometry
    // ************************************************************
    localparam int XLEN           = 32;
    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = LINE_BITS / XLEN;
    localparam int WORD_SEL_BITS  = $clog2(WORDS_PER_LINE);
    localparam int OFFSET_BITS    = $clog2(LINE_BITS / 8);
    localparam int ICACHE_LINES   = 16;
    localparam int INDEX_BITS     = $clog2(ICACHE_LINES);
    localparam int TAG_BITS       = XLEN - INDEX_BITS - OFFSET_BITS;

    // predictor is indexed by the pc above the two byte offset bits
    localparam int BP_ENTRIES    = 32;
    localparam int BP_INDEX_BITS = $clog2(BP_ENTRIES);
    localparam int BP_TAG_BITS   = XLEN - BP_INDEX_BITS - 2;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // major opcode fields seen by predecode
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_LINE,
        FILL
    } ctrl_state_e;

    typedef enum logic [1:0] {
        BRANCH,
        JAL,
        JALR,
        OTHER
    } opcode_e;

endpackage

// ==== hdl/fetch_stage.sv ====
module fetch_stage (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            stall_i,
    input  logic                            redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]      redirect_pc_i,
    input  logic                            upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]      upd_pc_i,
    input  logic                            upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0]      upd_target_i,
    output logic                            instr_valid_o,
    output logic [fetch_pkg::XLEN-1:0]      pc_o,
    output logic [fetch_pkg::XLEN-1:0]      instr_o,
    output logic                            pred_taken_o,
    output logic                            mem_req_o,
    output logic [fetch_pkg::XLEN-1:0]      mem_addr_o,
    input  logic                            mem_valid_i,
    input  logic [fetch_pkg::LINE_BITS-1:0] mem_line_i
);

    logic [fetch_pkg::XLEN-1:0]      fetch_pc;
    logic                            hit;
    logic [fetch_pkg::XLEN-1:0]      word;
    logic                            deliver;
    logic                            fill;
    logic [fetch_pkg::XLEN-1:0]      fill_addr;
    logic [fetch_pkg::LINE_BITS-1:0] fill_line;
    logic                            pred_taken;
    logic [fetch_pkg::XLEN-1:0]      pred_target;

    pc_gen pc_gen_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .stall_i          (stall_i),
        .deliver_i        (deliver),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .pred_taken_i     (pred_taken),
        .pred_target_i    (pred_target),
        .fetch_pc_o       (fetch_pc)
    );

    icache icache_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .fetch_pc_i  (fetch_pc),
        .fill_i      (fill),
        .fill_addr_i (fill_addr),
        .fill_line_i (fill_line),
        .hit_o       (hit),
        .word_o      (word)
    );

    icache_ctrl icache_ctrl_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .fetch_pc_i       (fetch_pc),
        .hit_i            (hit),
        .word_i           (word),
        .stall_i          (stall_i),
        .redirect_valid_i (redirect_valid_i),
        .mem_valid_i      (mem_valid_i),
        .mem_line_i       (mem_line_i),
        .deliver_o        (deliver),
        .fill_o           (fill),
        .fill_addr_o      (fill_addr),
        .fill_line_o      (fill_line),
        .mem_req_o        (mem_req_o),
        .mem_addr_o       (mem_addr_o),
        .instr_valid_o    (instr_valid_o),
        .pc_o             (pc_o),
        .instr_o          (instr_o)
    );

    branch_predictor branch_predictor_inst (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .fetch_pc_i       (fetch_pc),
        .word_i           (word),
        .deliver_i        (deliver),
        .upd_valid_i      (upd_valid_i),
        .upd_pc_i         (upd_pc_i),
        .upd_taken_i      (upd_taken_i),
        .upd_target_i     (upd_target_i),
        .pred_taken_o     (pred_taken),
        .pred_target_o    (pred_target),
        .pred_taken_reg_o (pred_taken_o)
    );

endmodule

// ==== hdl/icache.sv ====
module icache (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0]      fetch_pc_i,
    input  logic                            fill_i,
    input  logic [fetch_pkg::XLEN-1:0]      fill_addr_i,
    input  logic [fetch_pkg::LINE_BITS-1:0] fill_line_i,
    output logic                            hit_o,
    output logic [fetch_pkg::XLEN-1:0]      word_o
);

    logic [fetch_pkg::ICACHE_LINES-1:0] valid_q;
    logic [fetch_pkg::TAG_BITS-1:0]     tag_q  [fetch_pkg::ICACHE_LINES];
    logic [fetch_pkg::LINE_BITS-1:0]    data_q [fetch_pkg::ICACHE_LINES];

    logic [fetch_pkg::INDEX_BITS-1:0]    rd_idx;
    logic [fetch_pkg::TAG_BITS-1:0]      rd_tag;
    logic [fetch_pkg::WORD_SEL_BITS-1:0] rd_word;
    logic [fetch_pkg::INDEX_BITS-1:0]    wr_idx;
    logic [fetch_pkg::TAG_BITS-1:0]      wr_tag;
    logic [fetch_pkg::LINE_BITS-1:0]     rd_line;

    // ************************************************************
    // lookup
    // ************************************************************
    assign rd_idx  = fetch_pc_i[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
    assign rd_tag  = fetch_pc_i[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];
    assign rd_word = fetch_pc_i[2 +: fetch_pkg::WORD_SEL_BITS];

    assign rd_line = data_q[rd_idx];
    assign hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

    // word 0 of a line sits in the low bits
    assign word_o = rd_line[rd_word * fetch_pkg::XLEN +: fetch_pkg::XLEN];

    // ************************************************************
    // line fill
    // ************************************************************
    assign wr_idx = fill_addr_i[fetch_pkg::OFFSET_BITS +: fetch_pkg::INDEX_BITS];
    assign wr_tag = fill_addr_i[fetch_pkg::XLEN-1 -: fetch_pkg::TAG_BITS];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= fill_line_i;
        end
    end

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [fetch_pkg::XLEN-1:0]      fetch_pc_i,
    input  logic                            hit_i,
    input  logic [fetch_pkg::XLEN-1:0]      word_i,
    input  logic                            stall_i,
    input  logic                            redirect_valid_i,
    input  logic                            mem_valid_i,
    input  logic [fetch_pkg::LINE_BITS-1:0] mem_line_i,
    output logic                            deliver_o,
    output logic                            fill_o,
    output logic [fetch_pkg::XLEN-1:0]      fill_addr_o,
    output logic [fetch_pkg::LINE_BITS-1:0] fill_line_o,
    output logic                            mem_req_o,
    output logic [fetch_pkg::XLEN-1:0]      mem_addr_o,
    output logic                            instr_valid_o,
    output logic [fetch_pkg::XLEN-1:0]      pc_o,
    output logic [fetch_pkg::XLEN-1:0]      instr_o
);

    fetch_pkg::ctrl_state_e state_q;
    fetch_pkg::ctrl_state_e state_d;

    logic                            start_miss;
    logic                            mem_req_q;
    logic                            instr_valid_q;
    logic [fetch_pkg::XLEN-1:0]      miss_addr_q;
    logic [fetch_pkg::LINE_BITS-1:0] line_q;
    logic [fetch_pkg::XLEN-1:0]      pc_q;
    logic [fetch_pkg::XLEN-1:0]      instr_q;

    // a redirect moves the pc away, so a miss seen in that cycle is ignored
    assign start_miss = (state_q == fetch_pkg::IDLE) && !hit_i && !redirect_valid_i;
    assign deliver_o  = (state_q == fetch_pkg::IDLE) && hit_i && !stall_i && !redirect_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            fetch_pkg::IDLE: begin
                if (start_miss) begin
                    state_d = fetch_pkg::REQUEST;
                end
            end
            fetch_pkg::REQUEST: state_d = fetch_pkg::WAIT_LINE;
            fetch_pkg::WAIT_LINE: begin
                if (mem_valid_i) begin
                    state_d = fetch_pkg::FILL;
                end
            end
            default: state_d = fetch_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= fetch_pkg::IDLE;
            mem_req_q     <= 1'b0;
            instr_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            mem_req_q     <= start_miss;
            instr_valid_q <= deliver_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_miss) begin
            miss_addr_q <= {fetch_pc_i[fetch_pkg::XLEN-1:fetch_pkg::OFFSET_BITS],
                            {fetch_pkg::OFFSET_BITS{1'b0}}};
        end
        if ((state_q == fetch_pkg::WAIT_LINE) && mem_valid_i) begin
            line_q <= mem_line_i;
        end
        if (deliver_o) begin
            pc_q    <= fetch_pc_i;
            instr_q <= word_i;
        end
    end

    assign mem_req_o     = mem_req_q;
    assign mem_addr_o    = miss_addr_q;
    assign fill_o        = (state_q == fetch_pkg::FILL);
    assign fill_addr_o   = miss_addr_q;
    assign fill_line_o   = line_q;
    assign instr_valid_o = instr_valid_q;
    assign pc_o          = pc_q;
    assign instr_o       = instr_q;

    mem_req_single_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) mem_req_o |=> !mem_req_o
    );
    mem_req_state_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) mem_req_o |-> state_q == fetch_pkg::REQUEST
    );

endmodule

// ==== hdl/pc_gen.sv ====
module pc_gen (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       stall_i,
    input  logic                       deliver_i,
    input  logic                       redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                       pred_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] pred_target_i,
    output logic [fetch_pkg::XLEN-1:0] fetch_pc_o
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] pc_d;

    // redirect wins, then hold, then the predicted target, then pc + 4
    always_comb begin
        if (redirect_valid_i) begin
            pc_d = redirect_pc_i;
        end else if (stall_i || !deliver_i) begin
            pc_d = pc_q;
        end else if (pred_taken_i) begin
            pc_d = pred_target_i;
        end else begin
            pc_d = pc_q + fetch_pkg::XLEN'(4);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign fetch_pc_o = pc_q;

    // redirect and predictor targets come from outside and must keep the pc aligned
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) fetch_pc_o[1:0] == 2'b00
    );

endmodule

// ==== tb.f ====
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/icache.sv
hdl/icache_ctrl.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
bench/fetch_tb.sv
